//--- source/oq_pkg.sv
////////////////////////////////////////////////////////////
// Output queue package
// Stream widths, shared types and the fixed frame header
////////////////////////////////////////////////////////////
package oq_pkg;

    // Stream geometry
    localparam int DATA_W    = 64;
    localparam int STRB_W    = 8;

    // Two queues in the tree, one mask bit each
    localparam int NUM_PORTS = 2;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [STRB_W-1:0]    strb_t;

    // Bit 0 selects port 0, bit 1 selects port 1
    typedef logic [NUM_PORTS-1:0] port_mask_t;

    // Payload words per frame, 1 to 255
    typedef logic [7:0]           pkt_len_t;
    typedef logic [7:0]           gap_len_t;
    typedef logic [15:0]          drop_count_t;

    ////////////////////////////////////////////////////////////
    // Frame header
    ////////////////////////////////////////////////////////////

    // Destination address
    localparam data_t HDR_WORD0 = 64'hEFBE_FECA_FECA_FECA;

    // Source address plus type field
    localparam data_t HDR_WORD1 = 64'h0000_0008_EFBE_EFBE;

endpackage

//--- source/oq_pkt_source.sv
////////////////////////////////////////////////////////////
// Packet source
// Builds frames of two header words, a counted payload and
// an idle gap, and sends them over a valid/ready stream
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module oq_pkt_source (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  oq_pkg::port_mask_t  dst_mask,
    input  oq_pkg::pkt_len_t    payload_len,
    input  oq_pkg::gap_len_t    gap_len,
    input  logic                src_ready,
    output oq_pkg::data_t       src_data,
    output oq_pkg::strb_t       src_strb,
    output logic                src_valid,
    output logic                src_last,
    output oq_pkg::port_mask_t  src_mask,
    output logic                active
);

    typedef enum logic [1:0] {HEADER_0, HEADER_1, PAYLOAD, GAP} state_t;

    state_t              state;
    oq_pkg::pkt_len_t    word_cnt;
    oq_pkg::gap_len_t    gap_cnt;
    oq_pkg::pkt_len_t    len_q;
    oq_pkg::port_mask_t  mask_q;

    logic xfer;
    logic last_word;
    logic frame_end;
    logic start_frame;

    assign xfer      = src_valid && src_ready;
    assign last_word = (state == PAYLOAD) && (word_cnt == len_q - 8'd1);

    // Frame is over at the end of the gap, or right after the
    // last word when no gap is asked for
    assign frame_end = active &&
                       (((state == GAP) && (gap_cnt == gap_len)) ||
                        (xfer && last_word && (gap_len == 8'd0)));

    assign start_frame = enable && (!active || frame_end);

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            state    <= HEADER_0;
            word_cnt <= '0;
            gap_cnt  <= '0;
            len_q    <= '0;
            mask_q   <= '0;
        end else if (start_frame) begin
            // Mask and length hold for the whole frame
            active   <= 1'b1;
            state    <= HEADER_0;
            word_cnt <= '0;
            len_q    <= payload_len;
            mask_q   <= dst_mask;
        end else if (frame_end) begin
            active <= 1'b0;
        end else if (active) begin
            case (state)
                HEADER_0: if (xfer) state <= HEADER_1;
                HEADER_1: if (xfer) state <= PAYLOAD;
                PAYLOAD: begin
                    if (xfer) begin
                        if (last_word) begin
                            state   <= GAP;
                            gap_cnt <= 8'd1;
                        end else begin
                            word_cnt <= word_cnt + 8'd1;
                        end
                    end
                end
                GAP: gap_cnt <= gap_cnt + 8'd1;
                default: state <= HEADER_0;
            endcase
        end
    end

    // Output word from the current state
    always_comb begin
        case (state)
            HEADER_0: src_data = oq_pkg::HDR_WORD0;
            HEADER_1: src_data = oq_pkg::HDR_WORD1;
            PAYLOAD:  src_data = {8{word_cnt}};
            default:  src_data = '0;
        endcase
    end

    assign src_valid = active && (state != GAP);
    assign src_last  = last_word;
    assign src_strb  = '1;
    assign src_mask  = mask_q;

    // Stream holds its word until the controller takes it
    a_src_stable: assert property (@(posedge clk) disable iff (reset)
        src_valid && !src_ready |=> src_valid && $stable(src_data) &&
            $stable(src_strb) && $stable(src_last) && $stable(src_mask));

endmodule

//--- source/oq_input_ctrl.sv
////////////////////////////////////////////////////////////
// Input controller
// Routes each frame to the queues its mask selects, derives
// the source ready from queue space, counts empty-mask frames
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module oq_input_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  oq_pkg::data_t        src_data,
    input  oq_pkg::strb_t        src_strb,
    input  logic                 src_valid,
    input  logic                 src_last,
    input  oq_pkg::port_mask_t   src_mask,
    input  logic                 q_full_0,
    input  logic                 q_full_1,
    output logic                 src_ready,
    output oq_pkg::data_t        wr_data,
    output oq_pkg::strb_t        wr_strb,
    output logic                 wr_last,
    output logic                 q_wr_0,
    output logic                 q_wr_1,
    output oq_pkg::drop_count_t  drop_count
);

    typedef enum logic {FIRST_WORD, IN_FRAME} state_t;

    state_t              state;
    oq_pkg::port_mask_t  mask_q;
    oq_pkg::port_mask_t  cur_mask;
    logic                xfer;

    // Mask comes straight from the stream on the first word
    assign cur_mask = (state == FIRST_WORD) ? src_mask : mask_q;

    // A selected queue without space stalls the whole frame
    assign src_ready = !(cur_mask[0] && q_full_0) &&
                       !(cur_mask[1] && q_full_1);

    assign xfer = src_valid && src_ready;

    assign q_wr_0  = xfer && cur_mask[0];
    assign q_wr_1  = xfer && cur_mask[1];
    assign wr_data = src_data;
    assign wr_strb = src_strb;
    assign wr_last = src_last;

    ////////////////////////////////////////////////////////////
    // Frame tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= FIRST_WORD;
            mask_q <= '0;
        end else if (xfer) begin
            if (state == FIRST_WORD) begin
                mask_q <= src_mask;
            end
            if (src_last) begin
                state <= FIRST_WORD;
            end else begin
                state <= IN_FRAME;
            end
        end
    end

    // Frames with no destination are consumed here
    always_ff @(posedge clk) begin
        if (reset) begin
            drop_count <= '0;
        end else if (xfer && src_last && (cur_mask == '0)) begin
            drop_count <= drop_count + 16'd1;
        end
    end

endmodule

//--- source/oq_port_queue.sv
////////////////////////////////////////////////////////////
// Port queue
// Word FIFO for one output port with a registered output
// stage driving a valid/ready stream
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module oq_port_queue #(
    parameter int QUEUE_DEPTH = 64
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           wr,
    input  oq_pkg::data_t  wr_data,
    input  oq_pkg::strb_t  wr_strb,
    input  logic           wr_last,
    input  logic           m_ready,
    output logic           full,
    output oq_pkg::data_t  m_data,
    output oq_pkg::strb_t  m_strb,
    output logic           m_last,
    output logic           m_valid
);

    localparam int AW    = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 2);

    localparam logic [CNT_W-1:0] MEM_MAX = CNT_W'(QUEUE_DEPTH);
    localparam logic [CNT_W-1:0] OCC_MAX = CNT_W'(QUEUE_DEPTH + 1);

    // Storage
    oq_pkg::data_t  mem_data [QUEUE_DEPTH];
    oq_pkg::strb_t  mem_strb [QUEUE_DEPTH];
    logic           mem_last [QUEUE_DEPTH];

    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] mem_used;
    logic             load;
    logic             m_xfer;

    // Occupancy includes the word sitting in the output stage
    assign mem_used = count - {{(CNT_W-1){1'b0}}, m_valid};
    assign full     = (mem_used == MEM_MAX);

    assign m_xfer = m_valid && m_ready;
    assign load   = (!m_valid || m_ready) && (mem_used != '0);

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr) begin
            mem_data[wr_ptr] <= wr_data;
            mem_strb[wr_ptr] <= wr_strb;
            mem_last[wr_ptr] <= wr_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////////////////////////

    // Refill when empty or when the held word leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
            rd_ptr  <= '0;
        end else if (load) begin
            m_valid <= 1'b1;
            rd_ptr  <= rd_ptr + 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            m_data <= mem_data[rd_ptr];
            m_strb <= mem_strb[rd_ptr];
            m_last <= mem_last[rd_ptr];
        end
    end

    // Total words held
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr, m_xfer})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Writer holds off while the memory is full
    a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        wr |-> !full);

    a_occupancy: assert property (@(posedge clk) disable iff (reset)
        count <= OCC_MAX);

    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_data) &&
            $stable(m_strb) && $stable(m_last));

endmodule

//--- source/oq_top.sv
////////////////////////////////////////////////////////////
// Output queue top
// Packet source and input controller feeding two port queues
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module oq_top #(
    parameter int QUEUE_DEPTH = 64
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  oq_pkg::port_mask_t   dst_mask,
    input  oq_pkg::pkt_len_t     payload_len,
    input  oq_pkg::gap_len_t     gap_len,
    input  logic                 m_ready_0,
    input  logic                 m_ready_1,
    output oq_pkg::data_t        m_data_0,
    output oq_pkg::strb_t        m_strb_0,
    output logic                 m_last_0,
    output logic                 m_valid_0,
    output oq_pkg::data_t        m_data_1,
    output oq_pkg::strb_t        m_strb_1,
    output logic                 m_last_1,
    output logic                 m_valid_1,
    output logic                 active,
    output oq_pkg::drop_count_t  drop_count
);

    // Source to controller stream
    oq_pkg::data_t       src_data;
    oq_pkg::strb_t       src_strb;
    oq_pkg::port_mask_t  src_mask;
    logic                src_valid;
    logic                src_last;
    logic                src_ready;

    // Controller to queues
    oq_pkg::data_t       wr_data;
    oq_pkg::strb_t       wr_strb;
    logic                wr_last;
    logic                q_wr_0;
    logic                q_wr_1;
    logic                q_full_0;
    logic                q_full_1;

    oq_pkt_source source0 (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .dst_mask    (dst_mask),
        .payload_len (payload_len),
        .gap_len     (gap_len),
        .src_ready   (src_ready),
        .src_data    (src_data),
        .src_strb    (src_strb),
        .src_valid   (src_valid),
        .src_last    (src_last),
        .src_mask    (src_mask),
        .active      (active)
    );

    oq_input_ctrl ctrl0 (
        .clk        (clk),
        .reset      (reset),
        .src_data   (src_data),
        .src_strb   (src_strb),
        .src_valid  (src_valid),
        .src_last   (src_last),
        .src_mask   (src_mask),
        .q_full_0   (q_full_0),
        .q_full_1   (q_full_1),
        .src_ready  (src_ready),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb),
        .wr_last    (wr_last),
        .q_wr_0     (q_wr_0),
        .q_wr_1     (q_wr_1),
        .drop_count (drop_count)
    );

    ////////////////////////////////////////////////////////////
    // Port queues
    ////////////////////////////////////////////////////////////

    oq_port_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
        .clk     (clk),
        .reset   (reset),
        .wr      (q_wr_0),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .wr_last (wr_last),
        .m_ready (m_ready_0),
        .full    (q_full_0),
        .m_data  (m_data_0),
        .m_strb  (m_strb_0),
        .m_last  (m_last_0),
        .m_valid (m_valid_0)
    );

    oq_port_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue1 (
        .clk     (clk),
        .reset   (reset),
        .wr      (q_wr_1),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .wr_last (wr_last),
        .m_ready (m_ready_1),
        .full    (q_full_1),
        .m_data  (m_data_1),
        .m_strb  (m_strb_1),
        .m_last  (m_last_1),
        .m_valid (m_valid_1)
    );

endmodule

//--- dv/oq_clkgen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module oq_clkgen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- dv/oq_tb.sv
////////////////////////////////////////////////////////////
// Output queue testbench
// Frame content, routing, back-pressure and empty-mask tests
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
module oq_tb;

    localparam int QUEUE_DEPTH = 16;
    localparam int EXP_MAX     = 8192;
    localparam int FRAME_PAD   = 16;
    // Cycle bound of each test, summed
    localparam int TEST_CYCLES = 20 + 7 * (16 + FRAME_PAD) + 8 * (20 + FRAME_PAD) +
                                 6 * (255 + FRAME_PAD) + 5 * (32 + FRAME_PAD);
    localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES + 1000;

    logic                 clk;
    logic                 reset;
    logic                 enable;
    oq_pkg::port_mask_t   dst_mask;
    oq_pkg::pkt_len_t     payload_len;
    oq_pkg::gap_len_t     gap_len;
    logic                 m_ready_0 = 1'b1;
    logic                 m_ready_1 = 1'b1;
    oq_pkg::data_t        m_data_0;
    oq_pkg::data_t        m_data_1;
    oq_pkg::strb_t        m_strb_0;
    oq_pkg::strb_t        m_strb_1;
    logic                 m_last_0;
    logic                 m_last_1;
    logic                 m_valid_0;
    logic                 m_valid_1;
    logic                 active;
    oq_pkg::drop_count_t  drop_count;

    // Expected words per port, in send order
    oq_pkg::data_t  exp_data [2][EXP_MAX];
    logic           exp_last [2][EXP_MAX];
    int             exp_wr [2] = '{0, 0};
    int             exp_rd [2] = '{0, 0};

    logic rand_ready = 1'b0;
    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;

    oq_clkgen clkgen0 (.clk(clk), .reset(reset));

    oq_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (
        .clk(clk), .reset(reset), .enable(enable), .dst_mask(dst_mask),
        .payload_len(payload_len), .gap_len(gap_len),
        .m_ready_0(m_ready_0), .m_ready_1(m_ready_1),
        .m_data_0(m_data_0), .m_strb_0(m_strb_0), .m_last_0(m_last_0),
        .m_valid_0(m_valid_0), .m_data_1(m_data_1), .m_strb_1(m_strb_1),
        .m_last_1(m_last_1), .m_valid_1(m_valid_1),
        .active(active), .drop_count(drop_count)
    );

    task automatic log_error(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
    endtask

    task automatic push_word(input int port, input oq_pkg::data_t data, input logic last);
        exp_data[port][exp_wr[port]] = data;
        exp_last[port][exp_wr[port]] = last;
        exp_wr[port]++;
    endtask

    // Header, header, then payload word k with byte k everywhere
    task automatic push_frame(input oq_pkg::port_mask_t mask, input oq_pkg::pkt_len_t len);
        logic [7:0] kb;
        for (int p = 0; p < 2; p++) begin
            if (mask[p]) begin
                push_word(p, oq_pkg::HDR_WORD0, 1'b0);
                push_word(p, oq_pkg::HDR_WORD1, 1'b0);
                for (int k = 0; k < int'(len); k++) begin
                    kb = 8'(k);
                    push_word(p, {8{kb}}, k == int'(len) - 1);
                end
            end
        end
    endtask

    // One frame per enable pulse, returns once the source is idle
    task automatic send_frame(input oq_pkg::port_mask_t mask, input oq_pkg::pkt_len_t len,
                              input oq_pkg::gap_len_t gap);
        push_frame(mask, len);
        @(posedge clk);
        dst_mask    <= mask;
        payload_len <= len;
        gap_len     <= gap;
        enable      <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        do @(posedge clk); while (active);
    endtask

    task automatic wait_drain();
        while (exp_rd[0] != exp_wr[0] || exp_rd[1] != exp_wr[1]) @(posedge clk);
    endtask

    always @(posedge clk) begin
        logic [31:0] rnd;
        rnd = $urandom;
        m_ready_0 <= rand_ready ? rnd[0] : 1'b1;
        m_ready_1 <= rand_ready ? rnd[1] : 1'b1;
        if (!reset) begin
            if (m_valid_0 && m_ready_0) exp_rd[0] <= exp_rd[0] + 1;
            if (m_valid_1 && m_ready_1) exp_rd[1] <= exp_rd[1] + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output stream checks
    ////////////////////////////////////////////////////////////

    // A word on a port must have been sent to that port
    a_port0_sent: assert property (@(posedge clk) disable iff (reset)
        m_valid_0 |-> exp_rd[0] != exp_wr[0])
        else log_error("port 0 shows a word that was not sent to it");
    a_port1_sent: assert property (@(posedge clk) disable iff (reset)
        m_valid_1 |-> exp_rd[1] != exp_wr[1])
        else log_error("port 1 shows a word that was not sent to it");

    a_port0_word: assert property (@(posedge clk) disable iff (reset)
        m_valid_0 && m_ready_0 |-> m_data_0 == exp_data[0][exp_rd[0]] &&
            m_last_0 == exp_last[0][exp_rd[0]] && m_strb_0 == 8'hFF)
        else log_error($sformatf("port 0 word %0d got %h last %b, expected %h last %b",
            exp_rd[0], m_data_0, m_last_0, exp_data[0][exp_rd[0]], exp_last[0][exp_rd[0]]));
    a_port1_word: assert property (@(posedge clk) disable iff (reset)
        m_valid_1 && m_ready_1 |-> m_data_1 == exp_data[1][exp_rd[1]] &&
            m_last_1 == exp_last[1][exp_rd[1]] && m_strb_1 == 8'hFF)
        else log_error($sformatf("port 1 word %0d got %h last %b, expected %h last %b",
            exp_rd[1], m_data_1, m_last_1, exp_data[1][exp_rd[1]], exp_last[1][exp_rd[1]]));

    a_port0_hold: assert property (@(posedge clk) disable iff (reset)
        m_valid_0 && !m_ready_0 |=> m_valid_0 && $stable(m_data_0) &&
            $stable(m_strb_0) && $stable(m_last_0))
        else log_error("port 0 output changed while stalled");
    a_port1_hold: assert property (@(posedge clk) disable iff (reset)
        m_valid_1 && !m_ready_1 |=> m_valid_1 && $stable(m_data_1) &&
            $stable(m_strb_1) && $stable(m_last_1))
        else log_error("port 1 output changed while stalled");

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int                   err_mark;
        oq_pkg::drop_count_t  drop_start;
        logic [1:0]           route [8];
        void'($urandom(32'hd5cf220f));
        route = '{2'b01, 2'b10, 2'b11, 2'b10, 2'b11, 2'b01, 2'b11, 2'b10};
        enable      = 1'b0;
        dst_mask    = '0;
        payload_len = 8'd1;
        gap_len     = '0;
        @(posedge clk);
        while (reset) @(posedge clk);

        err_mark = errors;
        assert (!m_valid_0 && !m_valid_1 && !active && drop_count == '0)
            else log_error("outputs not idle after reset");
        finish_test("reset", err_mark);

        err_mark = errors;
        send_frame(2'b01, 8'd1, 8'd0);
        send_frame(2'b01, 8'd2, 8'd3);
        send_frame(2'b01, 8'd5, 8'd1);
        send_frame(2'b01, 8'd16, 8'd0);
        send_frame(2'b10, 8'd1, 8'd2);
        send_frame(2'b10, 8'd3, 8'd0);
        send_frame(2'b10, 8'd9, 8'd4);
        wait_drain();
        finish_test("frame content", err_mark);

        err_mark = errors;
        for (int n = 0; n < 8; n++) begin
            send_frame(route[n], 8'($urandom_range(20, 1)), 8'($urandom_range(7, 0)));
        end
        wait_drain();
        finish_test("routing", err_mark);

        err_mark = errors;
        @(posedge clk);
        rand_ready <= 1'b1;
        for (int n = 0; n < 6; n++) begin
            send_frame((n == 4) ? 2'b01 : (n == 5) ? 2'b10 : 2'b11,
                       8'($urandom_range(255, 150)), 8'($urandom_range(3, 0)));
        end
        wait_drain();
        rand_ready <= 1'b0;
        finish_test("back-pressure", err_mark);

        err_mark = errors;
        drop_start = drop_count;
        for (int n = 0; n < 5; n++) begin
            send_frame(2'b00, 8'($urandom_range(32, 1)), 8'($urandom_range(7, 0)));
        end
        repeat (2) @(posedge clk);
        assert (drop_count == drop_start + 16'd5)
            else log_error($sformatf("drop_count is %0d, expected %0d",
                drop_count, drop_start + 16'd5));
        finish_test("empty mask", err_mark);

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

//--- src.f
source/oq_pkg.sv
source/oq_pkt_source.sv
source/oq_input_ctrl.sv
source/oq_port_queue.sv
source/oq_top.sv
dv/oq_clkgen.sv
dv/oq_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the output queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module oq_tb \
    -f src.f --Mdir obj_dir -o oq_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/oq_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
